/* exu_top.f */
+incdir+common
common/exu_pkg.sv
src/exu_control.sv
src/alu.sv
src/reg_file.sv
csr/csr_file.sv
src/retire_unit.sv
src/exu_top.sv
verif/exu_assertions.sv
verif/exu_tb.sv

/* Bender.yml */
package:
  name: exu

export_include_dirs:
  - common

sources:
  - common/exu_pkg.sv
  - src/exu_control.sv
  - src/alu.sv
  - src/reg_file.sv
  - csr/csr_file.sv
  - src/retire_unit.sv
  - src/exu_top.sv
  - target: test
    files:
      - verif/exu_assertions.sv
      - verif/exu_tb.sv

/* verif/exu_tb.sv */
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_tb;

    localparam int N_SEED = 31;
    localparam int N_ALU = 40;
    localparam int N_BR = 24;
    // x0, csr, trap and ebreak tests together
    localparam int N_FIXED = 26;
    localparam int TOTAL_CYCLES = 2 + N_SEED + N_ALU + N_BR + N_FIXED;

    logic clk;
    logic rst;
    exu_pkg::exu_req_t req;
    exu_pkg::commit_t commit;

    // reference model state
    logic [`XLEN-1:0] m_regs [0:31];
    logic [`XLEN-1:0] m_mtvec;
    logic [`XLEN-1:0] m_mepc;
    logic [`XLEN-1:0] m_mcause;
    logic [`XLEN-1:0] m_mstatus;
    logic [63:0] rng_state = 64'd54;
    int checks;
    int errors;
    int test_errors;

    exu_top exu_top_inst (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .commit (commit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run length plus margin
    initial begin
        #((TOTAL_CYCLES + 20) * 100);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    // 64-bit lcg, output folded so low bits vary too
    function automatic logic [63:0] next_rand();
        rng_state = rng_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return rng_state ^ (rng_state >> 32);
    endfunction

    function automatic logic [63:0] rand_imm12();
        logic [63:0] r;
        r = next_rand();
        return {{52{r[11]}}, r[11:0]};
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [63:0] r;
        r = next_rand();
        return r[63:59];
    endfunction

    function automatic logic [63:0] csr_read(input logic [11:0] addr);
        case (addr)
            `CSR_MTVEC:   return m_mtvec;
            `CSR_MEPC:    return m_mepc;
            `CSR_MCAUSE:  return m_mcause;
            `CSR_MSTATUS: return m_mstatus;
            default:      return '0;
        endcase
    endfunction

    task automatic csr_write(input logic [11:0] addr, input logic [63:0] val);
        case (addr)
            `CSR_MTVEC:   m_mtvec = val;
            `CSR_MEPC:    m_mepc = val;
            `CSR_MCAUSE:  m_mcause = val;
            `CSR_MSTATUS: m_mstatus = val;
            default: ;
        endcase
    endtask

    // rv64 branch conditions on the two source registers
    function automatic logic branch_taken(input exu_pkg::op_e op, input logic [63:0] a,
                                          input logic [63:0] b);
        case (op)
            exu_pkg::OP_BEQ:  return a == b;
            exu_pkg::OP_BNE:  return a != b;
            exu_pkg::OP_BLT:  return $signed(a) < $signed(b);
            exu_pkg::OP_BGE:  return $signed(a) >= $signed(b);
            exu_pkg::OP_BLTU: return a < b;
            default:          return a >= b;
        endcase
    endfunction

    // expected commit from the old state, then state update
    task automatic model_exec(input exu_pkg::exu_req_t r, output exu_pkg::commit_t e);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] old;
        logic [5:0] sh;
        a = m_regs[r.rs1];
        b = r.use_imm ? r.imm : m_regs[r.rs2];
        sh = b[5:0];
        old = csr_read(r.imm[11:0]);
        e = '0;
        e.valid = (r.op != exu_pkg::OP_NOP);
        e.pc = r.pc;
        e.dnpc = r.pc + 64'd4;
        e.rd = r.rd;
        e.rf_wen = 1'b1;
        case (r.op)
            exu_pkg::OP_NOP:   e.rf_wen = 1'b0;
            exu_pkg::OP_ADD:   e.wdata = a + b;
            exu_pkg::OP_SUB:   e.wdata = a - b;
            exu_pkg::OP_SLL:   e.wdata = a << sh;
            exu_pkg::OP_SRL:   e.wdata = a >> sh;
            exu_pkg::OP_SRA:   e.wdata = $signed(a) >>> sh;
            exu_pkg::OP_SLT:   e.wdata = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            exu_pkg::OP_SLTU:  e.wdata = (a < b) ? 64'd1 : 64'd0;
            exu_pkg::OP_XOR:   e.wdata = a ^ b;
            exu_pkg::OP_OR:    e.wdata = a | b;
            exu_pkg::OP_AND:   e.wdata = a & b;
            exu_pkg::OP_LUI:   e.wdata = r.imm;
            exu_pkg::OP_AUIPC: e.wdata = r.pc + r.imm;
            exu_pkg::OP_JAL: begin
                e.wdata = r.pc + 64'd4;
                e.dnpc = r.pc + r.imm;
            end
            exu_pkg::OP_JALR: begin
                e.wdata = r.pc + 64'd4;
                e.dnpc = (a + r.imm) & ~64'd1;
            end
            exu_pkg::OP_CSRRW: begin
                e.wdata = old;
                csr_write(r.imm[11:0], a);
            end
            exu_pkg::OP_CSRRS: begin
                e.wdata = old;
                csr_write(r.imm[11:0], old | a);
            end
            // trap entry saves pc and cause
            exu_pkg::OP_ECALL: begin
                e.rf_wen = 1'b0;
                e.dnpc = m_mtvec;
                m_mepc = r.pc;
                m_mcause = `CAUSE_ECALL_M;
            end
            exu_pkg::OP_MRET: begin
                e.rf_wen = 1'b0;
                e.dnpc = m_mepc;
            end
            exu_pkg::OP_EBREAK: begin
                e.rf_wen = 1'b0;
                e.halt = 1'b1;
                e.halt_bad = (m_regs[10] != '0);
            end
            // the six branches
            default: begin
                e.rf_wen = 1'b0;
                if (branch_taken(r.op, m_regs[r.rs1], m_regs[r.rs2])) begin
                    e.dnpc = r.pc + r.imm;
                end
            end
        endcase
        if (e.rf_wen && r.rd != '0) begin
            m_regs[r.rd] = e.wdata;
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare(input exu_pkg::commit_t e);
        check_val("commit.valid", commit.valid, e.valid);
        check_val("commit.rf_wen", commit.rf_wen, e.rf_wen);
        check_val("commit.halt", commit.halt, e.halt);
        if (e.valid) begin
            check_val("commit.pc", commit.pc, e.pc);
            check_val("commit.dnpc", commit.dnpc, e.dnpc);
            check_val("commit.halt_bad", commit.halt_bad, e.halt_bad);
        end
        // rd and wdata only mean something on a write
        if (e.rf_wen) begin
            check_val("commit.rd", commit.rd, e.rd);
            check_val("commit.wdata", commit.wdata, e.wdata);
        end
    endtask

    // one instruction per cycle, checked mid-cycle
    task automatic issue(input exu_pkg::op_e op, input logic use_imm, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2, input logic [63:0] imm);
        exu_pkg::exu_req_t r;
        exu_pkg::commit_t e;
        r.op = op;
        r.rd = rd;
        r.rs1 = rs1;
        r.rs2 = rs2;
        r.use_imm = use_imm;
        r.imm = imm;
        r.pc = next_rand() & ~64'd3;
        @(posedge clk);
        req <= r;
        @(negedge clk);
        model_exec(r, e);
        compare(e);
    endtask

    task automatic read_all_csrs(input logic [4:0] rd);
        issue(exu_pkg::OP_CSRRS, 1'b0, rd, 5'd0, 5'd0, 64'(`CSR_MTVEC));
        issue(exu_pkg::OP_CSRRS, 1'b0, rd, 5'd0, 5'd0, 64'(`CSR_MEPC));
        issue(exu_pkg::OP_CSRRS, 1'b0, rd, 5'd0, 5'd0, 64'(`CSR_MCAUSE));
        issue(exu_pkg::OP_CSRRS, 1'b0, rd, 5'd0, 5'd0, 64'(`CSR_MSTATUS));
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        exu_pkg::op_e op;
        logic [63:0] r;
        logic [2:0] k;
        int i;
        rst = 1'b1;
        req = '0;
        checks = 0;
        errors = 0;
        test_errors = 0;
        for (i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_mtvec = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_mstatus = `MSTATUS_RESET;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // fill x1..x31 with random values first
        for (i = 1; i < 32; i++) begin
            issue(exu_pkg::OP_ADD, 1'b1, 5'(i), 5'd0, 5'd0, next_rand());
        end
        for (i = 0; i < N_ALU; i++) begin
            r = next_rand();
            // add..and, lui, auipc
            op = exu_pkg::op_e'(5'(r[63:60] % 4'd12) + 5'd1);
            if (op == exu_pkg::OP_LUI) begin
                issue(op, 1'b0, r[58:54], r[53:49], r[48:44],
                      {{32{r[31]}}, r[31:12], 12'b0});
            end else begin
                issue(op, r[0], r[58:54], r[53:49], r[48:44], rand_imm12());
            end
        end
        end_test("alu");

        issue(exu_pkg::OP_ADD, 1'b1, 5'd0, 5'd5, 5'd0, rand_imm12());
        issue(exu_pkg::OP_ADD, 1'b0, 5'd6, 5'd0, 5'd0, '0);
        issue(exu_pkg::OP_OR, 1'b0, 5'd7, 5'd0, 5'd0, '0);
        end_test("x0");

        for (i = 0; i < N_BR; i++) begin
            r = next_rand();
            k = r[63:61];
            if (k < 3'd6) begin
                op = exu_pkg::op_e'(exu_pkg::OP_BEQ + 5'(k));
            end else begin
                op = (k == 3'd6) ? exu_pkg::OP_JAL : exu_pkg::OP_JALR;
            end
            // rs2 equal to rs1 half the time
            issue(op, 1'b0, r[58:54], r[53:49], r[0] ? r[53:49] : r[48:44],
                  rand_imm12() & ~64'd1);
        end
        end_test("branch");

        read_all_csrs(5'd11);
        issue(exu_pkg::OP_CSRRW, 1'b0, 5'd12, rand_reg(), 5'd0, 64'(`CSR_MTVEC));
        issue(exu_pkg::OP_CSRRS, 1'b0, 5'd13, rand_reg(), 5'd0, 64'(`CSR_MSTATUS));
        issue(exu_pkg::OP_CSRRW, 1'b0, 5'd14, rand_reg(), 5'd0, 64'(`CSR_MEPC));
        // unmapped address reads zero
        issue(exu_pkg::OP_CSRRS, 1'b0, 5'd15, rand_reg(), 5'd0, 64'h7c0);
        read_all_csrs(5'd11);
        end_test("csr");

        issue(exu_pkg::OP_CSRRW, 1'b0, 5'd16, rand_reg(), 5'd0, 64'(`CSR_MTVEC));
        issue(exu_pkg::OP_ECALL, 1'b0, 5'd0, 5'd0, 5'd0, '0);
        issue(exu_pkg::OP_CSRRS, 1'b0, 5'd17, 5'd0, 5'd0, 64'(`CSR_MEPC));
        issue(exu_pkg::OP_CSRRS, 1'b0, 5'd18, 5'd0, 5'd0, 64'(`CSR_MCAUSE));
        issue(exu_pkg::OP_MRET, 1'b0, 5'd0, 5'd0, 5'd0, '0);
        end_test("trap");

        // ebreak with a0 as left, then a0 = 0 and a0 = 1
        issue(exu_pkg::OP_EBREAK, 1'b0, 5'd0, 5'd0, 5'd0, '0);
        issue(exu_pkg::OP_ADD, 1'b1, 5'd10, 5'd0, 5'd0, '0);
        issue(exu_pkg::OP_EBREAK, 1'b0, 5'd0, 5'd0, 5'd0, '0);
        issue(exu_pkg::OP_ADD, 1'b1, 5'd10, 5'd0, 5'd0, 64'd1);
        issue(exu_pkg::OP_EBREAK, 1'b0, 5'd0, 5'd0, 5'd0, '0);
        issue(exu_pkg::OP_NOP, 1'b0, 5'd0, 5'd0, 5'd0, '0);
        end_test("ebreak");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verif/exu_assertions.sv */
`timescale 1ns/1ps

module exu_assertions (
    input logic              clk,
    input logic              rst,
    input exu_pkg::exu_req_t req,
    input exu_pkg::commit_t  commit
);

    // nothing retires while in reset
    assert property (@(posedge clk) rst |-> !commit.valid)
        else $error("commit.valid high during reset");

    // idle cycle
    assert property (@(posedge clk) (req.op == exu_pkg::OP_NOP) |-> !commit.valid)
        else $error("commit.valid high for a nop request");

    assert property (@(posedge clk) commit.halt |-> commit.valid)
        else $error("commit.halt without commit.valid");

    // a register write needs a retiring instruction
    assert property (@(posedge clk) commit.rf_wen |-> commit.valid)
        else $error("commit.rf_wen without commit.valid");

endmodule

bind exu_top exu_assertions exu_assertions_inst (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .commit (commit)
);

/* src/exu_top.sv */
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_top (
    input  logic             clk,
    input  logic             rst,
    input  exu_pkg::exu_req_t req,
    output exu_pkg::commit_t  commit
);

    exu_pkg::exu_ctrl_t ctrl;
    logic [`XLEN-1:0]   rs1_val;
    logic [`XLEN-1:0]   rs2_val;
    logic [`XLEN-1:0]   a0_val;
    logic [`XLEN-1:0]   alu_res;
    logic [`XLEN-1:0]   csr_rdata;
    logic [`XLEN-1:0]   mtvec;
    logic [`XLEN-1:0]   mepc;
    logic               rf_wen;
    logic [`XLEN-1:0]   wdata;

    // operand muxes in front of the alu
    wire [`XLEN-1:0] alu_a = (ctrl.opa_sel == exu_pkg::OPA_PC) ? req.pc : rs1_val;
    wire [`XLEN-1:0] alu_b = (ctrl.opb_sel == exu_pkg::OPB_IMM) ? req.imm :
                             (ctrl.opb_sel == exu_pkg::OPB_CSR) ? csr_rdata : rs2_val;

    exu_control exu_control_inst (
        .op      (req.op),
        .use_imm (req.use_imm),
        .ctrl    (ctrl)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .rst     (rst),
        .rs1     (req.rs1),
        .rs2     (req.rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .a0_val  (a0_val),
        .wen     (rf_wen),
        .rd      (req.rd),
        .wdata   (wdata)
    );

    alu alu_inst (
        .mode (ctrl.alu_mode),
        .a    (alu_a),
        .b    (alu_b),
        .res  (alu_res)
    );

    // csr address taken straight from the immediate
    csr_file csr_file_inst (
        .clk     (clk),
        .rst     (rst),
        .cmd     (ctrl.csr_cmd),
        .addr    (req.imm[`CSR_AW-1:0]),
        .pc      (req.pc),
        .rs1_val (rs1_val),
        .alu_res (alu_res),
        .rdata   (csr_rdata),
        .mtvec   (mtvec),
        .mepc    (mepc)
    );

    retire_unit retire_unit_inst (
        .req       (req),
        .ctrl      (ctrl),
        .alu_res   (alu_res),
        .csr_rdata (csr_rdata),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .a0_val    (a0_val),
        .rf_wen    (rf_wen),
        .wdata     (wdata),
        .commit    (commit)
    );

endmodule

/* src/retire_unit.sv */
`timescale 1ns/1ps
`include "exu_macros.svh"

module retire_unit (
    input  exu_pkg::exu_req_t  req,
    input  exu_pkg::exu_ctrl_t ctrl,
    input  logic [`XLEN-1:0]   alu_res,
    input  logic [`XLEN-1:0]   csr_rdata,
    input  logic [`XLEN-1:0]   mtvec,
    input  logic [`XLEN-1:0]   mepc,
    input  logic [`XLEN-1:0]   a0_val,
    output logic               rf_wen,
    output logic [`XLEN-1:0]   wdata,
    output exu_pkg::commit_t   commit
);

    logic [`XLEN-1:0] snpc;
    logic [`XLEN-1:0] br_target;
    logic [`XLEN-1:0] dnpc;

    assign snpc      = req.pc + `XLEN'(`INST_BYTES);
    assign br_target = req.pc + req.imm;

    // register writeback source
    always_comb begin
        case (ctrl.wb_sel)
            exu_pkg::WB_IMM: wdata = req.imm;
            exu_pkg::WB_PC4: wdata = snpc;
            exu_pkg::WB_CSR: wdata = csr_rdata;
            default:         wdata = alu_res;
        endcase
    end

    // next pc, branches test the alu result against zero
    always_comb begin
        case (ctrl.npc_sel)
            exu_pkg::NPC_JUMP:       dnpc = alu_res;
            exu_pkg::NPC_JALR:       dnpc = {alu_res[`XLEN-1:1], 1'b0};
            exu_pkg::NPC_BR_ZERO:    dnpc = (alu_res == '0) ? br_target : snpc;
            exu_pkg::NPC_BR_NONZERO: dnpc = (alu_res != '0) ? br_target : snpc;
            exu_pkg::NPC_TRAP:       dnpc = mtvec;
            exu_pkg::NPC_RET:        dnpc = mepc;
            default:                 dnpc = snpc;
        endcase
    end

    assign rf_wen = ctrl.rf_wen;

    always_comb begin
        commit.valid    = (req.op != exu_pkg::OP_NOP);
        commit.pc       = req.pc;
        commit.dnpc     = dnpc;
        commit.rf_wen   = ctrl.rf_wen;
        commit.rd       = req.rd;
        commit.wdata    = wdata;
        commit.halt     = ctrl.halt;
        // nonzero a0 at ebreak means the program failed
        commit.halt_bad = ctrl.halt && (a0_val != '0);
    end

endmodule

/* csr/csr_file.sv */
`timescale 1ns/1ps
`include "exu_macros.svh"

module csr_file (
    input  logic                clk,
    input  logic                rst,
    input  exu_pkg::csr_cmd_e   cmd,
    input  logic [`CSR_AW-1:0]  addr,
    input  logic [`XLEN-1:0]    pc,
    input  logic [`XLEN-1:0]    rs1_val,
    input  logic [`XLEN-1:0]    alu_res,
    output logic [`XLEN-1:0]    rdata,
    output logic [`XLEN-1:0]    mtvec,
    output logic [`XLEN-1:0]    mepc
);

    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;
    logic [`XLEN-1:0] mstatus_q;
    logic [`XLEN-1:0] wval;

    // csrrs value already merged by the alu
    assign wval = (cmd == exu_pkg::CSR_SET) ? alu_res : rs1_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mstatus_q <= `MSTATUS_RESET;
        end else begin
            case (cmd)
                exu_pkg::CSR_WRITE, exu_pkg::CSR_SET: begin
                    // unknown addresses drop the write
                    case (addr)
                        `CSR_MTVEC:   mtvec_q   <= wval;
                        `CSR_MEPC:    mepc_q    <= wval;
                        `CSR_MCAUSE:  mcause_q  <= wval;
                        `CSR_MSTATUS: mstatus_q <= wval;
                        default: ;
                    endcase
                end
                // trap entry, save pc and cause
                exu_pkg::CSR_ECALL: begin
                    mepc_q   <= pc;
                    mcause_q <= `CAUSE_ECALL_M;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (addr)
            `CSR_MTVEC:   rdata = mtvec_q;
            `CSR_MEPC:    rdata = mepc_q;
            `CSR_MCAUSE:  rdata = mcause_q;
            `CSR_MSTATUS: rdata = mstatus_q;
            default:      rdata = '0;
        endcase
    end

    // trap and return targets for the retire unit
    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps
`include "exu_macros.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    output logic [`XLEN-1:0]   rs1_val,
    output logic [`XLEN-1:0]   rs2_val,
    output logic [`XLEN-1:0]   a0_val,
    input  logic               wen,
    input  logic [`REG_AW-1:0] rd,
    input  logic [`XLEN-1:0]   wdata
);

    localparam int NREGS  = 1 << `REG_AW;
    localparam int A0_IDX = 10;

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:NREGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // async reads, x0 forced to zero
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];
    // a0 carries the exit code on ebreak
    assign a0_val  = regs[A0_IDX];

endmodule

/* src/alu.sv */
`timescale 1ns/1ps
`include "exu_macros.svh"

module alu (
    input  exu_pkg::alu_mode_e mode,
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    output logic [`XLEN-1:0]   res
);

    // rv64 shifts only look at the low six bits
    logic [`SHAMT_W-1:0] shamt;

    assign shamt = b[`SHAMT_W-1:0];

    always_comb begin
        case (mode)
            exu_pkg::ALU_ADD:  res = a + b;
            exu_pkg::ALU_SUB:  res = a - b;
            exu_pkg::ALU_SLL:  res = a << shamt;
            exu_pkg::ALU_SRL:  res = a >> shamt;
            exu_pkg::ALU_SRA:  res = $signed(a) >>> shamt;
            // compares give a single bit, zero extended
            exu_pkg::ALU_SLT:  res = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            exu_pkg::ALU_SLTU: res = {{(`XLEN-1){1'b0}}, a < b};
            exu_pkg::ALU_XOR:  res = a ^ b;
            exu_pkg::ALU_OR:   res = a | b;
            exu_pkg::ALU_AND:  res = a & b;
            default:           res = '0;
        endcase
    end

endmodule

/* src/exu_control.sv */
`timescale 1ns/1ps

module exu_control (
    input  exu_pkg::op_e       op,
    input  logic               use_imm,
    output exu_pkg::exu_ctrl_t ctrl
);

    always_comb begin
        // idle defaults, operand b follows the imm flag
        ctrl.alu_mode = exu_pkg::ALU_ADD;
        ctrl.opa_sel  = exu_pkg::OPA_RS1;
        ctrl.opb_sel  = use_imm ? exu_pkg::OPB_IMM : exu_pkg::OPB_RS2;
        ctrl.wb_sel   = exu_pkg::WB_ALU;
        ctrl.rf_wen   = 1'b0;
        ctrl.npc_sel  = exu_pkg::NPC_SEQ;
        ctrl.csr_cmd  = exu_pkg::CSR_NONE;
        ctrl.halt     = 1'b0;

        case (op)
            exu_pkg::OP_ADD: begin
                ctrl.alu_mode = exu_pkg::ALU_ADD;
                ctrl.rf_wen   = 1'b1;
            end
            exu_pkg::OP_SUB: begin
                ctrl.alu_mode = exu_pkg::ALU_SUB;
                ctrl.rf_wen   = 1'b1;
            end
            exu_pkg::OP_SLL: begin
                ctrl.alu_mode = exu_pkg::ALU_SLL;
                ctrl.rf_wen   = 1'b1;
            end
            exu_pkg::OP_SRL: begin
                ctrl.alu_mode = exu_pkg::ALU_SRL;
                ctrl.rf_wen   = 1'b1;
            end
            exu_pkg::OP_SRA: begin
                ctrl.alu_mode = exu_pkg::ALU_SRA;
                ctrl.rf_wen   = 1'b1;
            end
            exu_pkg::OP_SLT: begin
                ctrl.alu_mode = exu_pkg::ALU_SLT;
                ctrl.rf_wen   = 1'b1;
            end
            exu_pkg::OP_SLTU: begin
                ctrl.alu_mode = exu_pkg::ALU_SLTU;
                ctrl.rf_wen   = 1'b1;
            end
            exu_pkg::OP_XOR: begin
                ctrl.alu_mode = exu_pkg::ALU_XOR;
                ctrl.rf_wen   = 1'b1;
            end
            exu_pkg::OP_OR: begin
                ctrl.alu_mode = exu_pkg::ALU_OR;
                ctrl.rf_wen   = 1'b1;
            end
            exu_pkg::OP_AND: begin
                ctrl.alu_mode = exu_pkg::ALU_AND;
                ctrl.rf_wen   = 1'b1;
            end
            // lui skips the alu, imm is already shifted
            exu_pkg::OP_LUI: begin
                ctrl.wb_sel = exu_pkg::WB_IMM;
                ctrl.rf_wen = 1'b1;
            end
            exu_pkg::OP_AUIPC: begin
                ctrl.opa_sel = exu_pkg::OPA_PC;
                ctrl.opb_sel = exu_pkg::OPB_IMM;
                ctrl.rf_wen  = 1'b1;
            end
            // link value is pc+4, target comes from the alu
            exu_pkg::OP_JAL: begin
                ctrl.opa_sel = exu_pkg::OPA_PC;
                ctrl.opb_sel = exu_pkg::OPB_IMM;
                ctrl.wb_sel  = exu_pkg::WB_PC4;
                ctrl.rf_wen  = 1'b1;
                ctrl.npc_sel = exu_pkg::NPC_JUMP;
            end
            exu_pkg::OP_JALR: begin
                ctrl.opb_sel = exu_pkg::OPB_IMM;
                ctrl.wb_sel  = exu_pkg::WB_PC4;
                ctrl.rf_wen  = 1'b1;
                ctrl.npc_sel = exu_pkg::NPC_JALR;
            end
            // equality via sub, ordering via slt/sltu
            exu_pkg::OP_BEQ, exu_pkg::OP_BNE: begin
                ctrl.alu_mode = exu_pkg::ALU_SUB;
                ctrl.opb_sel  = exu_pkg::OPB_RS2;
                ctrl.npc_sel  = (op == exu_pkg::OP_BEQ) ? exu_pkg::NPC_BR_ZERO
                                                        : exu_pkg::NPC_BR_NONZERO;
            end
            exu_pkg::OP_BLT, exu_pkg::OP_BGE: begin
                ctrl.alu_mode = exu_pkg::ALU_SLT;
                ctrl.opb_sel  = exu_pkg::OPB_RS2;
                ctrl.npc_sel  = (op == exu_pkg::OP_BLT) ? exu_pkg::NPC_BR_NONZERO
                                                        : exu_pkg::NPC_BR_ZERO;
            end
            exu_pkg::OP_BLTU, exu_pkg::OP_BGEU: begin
                ctrl.alu_mode = exu_pkg::ALU_SLTU;
                ctrl.opb_sel  = exu_pkg::OPB_RS2;
                ctrl.npc_sel  = (op == exu_pkg::OP_BLTU) ? exu_pkg::NPC_BR_NONZERO
                                                         : exu_pkg::NPC_BR_ZERO;
            end
            exu_pkg::OP_CSRRW: begin
                ctrl.wb_sel  = exu_pkg::WB_CSR;
                ctrl.rf_wen  = 1'b1;
                ctrl.csr_cmd = exu_pkg::CSR_WRITE;
            end
            // old csr or rs1, computed by the alu
            exu_pkg::OP_CSRRS: begin
                ctrl.alu_mode = exu_pkg::ALU_OR;
                ctrl.opb_sel  = exu_pkg::OPB_CSR;
                ctrl.wb_sel   = exu_pkg::WB_CSR;
                ctrl.rf_wen   = 1'b1;
                ctrl.csr_cmd  = exu_pkg::CSR_SET;
            end
            exu_pkg::OP_ECALL: begin
                ctrl.npc_sel = exu_pkg::NPC_TRAP;
                ctrl.csr_cmd = exu_pkg::CSR_ECALL;
            end
            exu_pkg::OP_MRET: ctrl.npc_sel = exu_pkg::NPC_RET;
            exu_pkg::OP_EBREAK: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

/* common/exu_pkg.sv */
`include "exu_macros.svh"

package exu_pkg;

    // decoded instruction, reg-imm forms use the use_imm flag
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA,
        OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_CSRRW, OP_CSRRS,
        OP_ECALL, OP_MRET, OP_EBREAK
    } op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND
    } alu_mode_e;

    typedef enum logic {OPA_RS1, OPA_PC} opa_sel_e;

    typedef enum logic [1:0] {OPB_RS2, OPB_IMM, OPB_CSR} opb_sel_e;

    typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_PC4, WB_CSR} wb_sel_e;

    // branch forms test the alu result against zero
    typedef enum logic [2:0] {
        NPC_SEQ, NPC_JUMP, NPC_JALR, NPC_BR_ZERO, NPC_BR_NONZERO, NPC_TRAP, NPC_RET
    } npc_sel_e;

    typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_ECALL} csr_cmd_e;

    typedef struct packed {
        op_e                op;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic               use_imm;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   pc;
    } exu_req_t;

    typedef struct packed {
        alu_mode_e alu_mode;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        wb_sel_e   wb_sel;
        logic      rf_wen;
        npc_sel_e  npc_sel;
        csr_cmd_e  csr_cmd;
        logic      halt;
    } exu_ctrl_t;

    // one retired instruction per valid cycle
    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   dnpc;
        logic               rf_wen;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   wdata;
        logic               halt;
        logic               halt_bad;
    } commit_t;

endpackage

/* common/exu_macros.svh */
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// datapath and pc width
`define XLEN 64
`define REG_AW 5
// csr address sits in the low bits of imm
`define CSR_AW 12

// machine csr addresses
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342
`define CSR_MSTATUS 12'h300

// mpp = machine, sxl/uxl = 64
`define MSTATUS_RESET 64'h0000_000a_0000_1800
`define CAUSE_ECALL_M 64'h0000_0000_0000_000b

`define INST_BYTES 4
`define SHAMT_W 6

`endif
